// ==== rtl/lc4_pkg.sv ====
`default_nettype none

package lc4_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_idx_t;
    // bit 2 negative, bit 1 zero, bit 0 positive
    typedef logic [2:0]  nzp_t;

    // major opcodes in insn[15:12]
    localparam logic [3:0] OP_BR      = 4'b0000;
    localparam logic [3:0] OP_ARITH   = 4'b0001;
    localparam logic [3:0] OP_LOGIC   = 4'b0101;
    localparam logic [3:0] OP_LDR     = 4'b0110;
    localparam logic [3:0] OP_STR     = 4'b0111;
    localparam logic [3:0] OP_CONST   = 4'b1001;
    localparam logic [3:0] OP_JMP     = 4'b1100;
    localparam logic [3:0] OP_HICONST = 4'b1101;

    // register-form subopcodes in insn[5:3]
    localparam logic [2:0] FN_ADD = 3'b000;
    localparam logic [2:0] FN_SUB = 3'b010;
    localparam logic [2:0] FN_AND = 3'b000;
    localparam logic [2:0] FN_NOT = 3'b001;
    localparam logic [2:0] FN_OR  = 3'b010;
    localparam logic [2:0] FN_XOR = 3'b011;

    typedef struct packed {
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rf_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        logic     is_jump;
        word_t    insn;
    } insn_ctrl_t;

    typedef struct packed {
        insn_ctrl_t ctrl;
        word_t      pc;
        word_t      rs_val;
        word_t      rt_val;
    } dx_t;

    typedef struct packed {
        insn_ctrl_t ctrl;
        word_t      pc;
        word_t      result;
        word_t      store_data;
    } xm_t;

    // mem_data is the loaded word for LDR and the stored word for STR
    typedef struct packed {
        insn_ctrl_t ctrl;
        word_t      pc;
        word_t      result;
        word_t      mem_data;
    } mw_t;

    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_FLUSH = 2'd2,
        STALL_LOAD  = 2'd3
    } stall_e;

    typedef enum logic [1:0] {BYP_REGFILE, BYP_FROM_M, BYP_FROM_W} bypass_e;

    typedef enum logic [1:0] {NZP_REG, NZP_FROM_M, NZP_FROM_W} nzp_src_e;

    typedef struct packed {
        stall_e   stall;
        word_t    pc;
        word_t    insn;
        logic     rf_we;
        reg_idx_t rf_wsel;
        word_t    rf_data;
        logic     nzp_we;
        nzp_t     nzp_bits;
        logic     dmem_we;
        word_t    dmem_addr;
        word_t    dmem_data;
    } trace_t;

endpackage

`default_nettype wire

// ==== rtl/lc4_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_decoder (
    input  wire lc4_pkg::word_t i_insn,
    output lc4_pkg::insn_ctrl_t o_ctrl
);

    logic [3:0] opcode;
    logic [2:0] fn;
    logic       imm_form;

    assign opcode   = i_insn[15:12];
    assign fn       = i_insn[5:3];
    assign imm_form = i_insn[5];

    always_comb begin
        o_ctrl      = '0;
        o_ctrl.insn = i_insn;
        o_ctrl.rd   = i_insn[11:9];
        o_ctrl.rs   = i_insn[8:6];
        o_ctrl.rt   = i_insn[2:0];
        case (opcode)
            lc4_pkg::OP_BR: begin
                // an empty mask is the NOP and never redirects
                o_ctrl.is_branch = |i_insn[11:9];
            end
            lc4_pkg::OP_ARITH: begin
                // MUL and DIV fall through as NOPs
                if (imm_form || fn == lc4_pkg::FN_ADD || fn == lc4_pkg::FN_SUB) begin
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rt_re  = !imm_form;
                    o_ctrl.rf_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end
            end
            lc4_pkg::OP_LOGIC: begin
                o_ctrl.rs_re  = 1'b1;
                o_ctrl.rt_re  = !imm_form && fn != lc4_pkg::FN_NOT;
                o_ctrl.rf_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end
            lc4_pkg::OP_LDR: begin
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rf_we   = 1'b1;
                o_ctrl.nzp_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            lc4_pkg::OP_STR: begin
                // store data register sits in the rd field
                o_ctrl.rt       = i_insn[11:9];
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end
            lc4_pkg::OP_CONST: begin
                o_ctrl.rf_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end
            lc4_pkg::OP_HICONST: begin
                // keeps the low byte of rd, so rd is also a source
                o_ctrl.rs     = i_insn[11:9];
                o_ctrl.rs_re  = 1'b1;
                o_ctrl.rf_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end
            lc4_pkg::OP_JMP: begin
                // JMPR (bit 11 clear) is not supported
                o_ctrl.is_jump = i_insn[11];
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/lc4_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile (
    input  wire                   gwe,
    input  wire                   i_rst_n,
    input  wire lc4_pkg::reg_idx_t i_rs,
    input  wire lc4_pkg::reg_idx_t i_rt,
    output lc4_pkg::word_t        o_rs_data,
    output lc4_pkg::word_t        o_rt_data,
    input  wire lc4_pkg::reg_idx_t i_rd,
    input  wire lc4_pkg::word_t   i_wdata,
    input  wire                   i_we
);

    lc4_pkg::word_t regs [8];

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            regs <= '{default: '0};
        end else if (i_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // a same-cycle write is visible to decode
    assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

`default_nettype wire

// ==== rtl/lc4_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_alu (
    input  wire lc4_pkg::insn_ctrl_t i_ctrl,
    input  wire lc4_pkg::word_t      i_pc,
    input  wire lc4_pkg::word_t      i_rs_val,
    input  wire lc4_pkg::word_t      i_rt_val,
    input  wire lc4_pkg::nzp_t       i_nzp,
    output lc4_pkg::word_t           o_result,
    output logic                     o_taken,
    output lc4_pkg::word_t           o_target
);

    lc4_pkg::word_t insn;
    logic [2:0]     fn;
    lc4_pkg::word_t imm5;
    lc4_pkg::word_t imm6;
    lc4_pkg::word_t imm9;
    lc4_pkg::word_t imm11;

    assign insn  = i_ctrl.insn;
    assign fn    = insn[5:3];
    assign imm5  = {{11{insn[4]}}, insn[4:0]};
    assign imm6  = {{10{insn[5]}}, insn[5:0]};
    assign imm9  = {{7{insn[8]}}, insn[8:0]};
    assign imm11 = {{5{insn[10]}}, insn[10:0]};

    // both BR and JMP are relative to the next sequential pc
    assign o_target = i_pc + 16'd1 + (i_ctrl.is_jump ? imm11 : imm9);
    assign o_taken  = i_ctrl.is_jump || (i_ctrl.is_branch && |(insn[11:9] & i_nzp));

    always_comb begin
        o_result = '0;
        case (insn[15:12])
            lc4_pkg::OP_ARITH: begin
                if (insn[5]) begin
                    o_result = i_rs_val + imm5;
                end else if (fn == lc4_pkg::FN_SUB) begin
                    o_result = i_rs_val - i_rt_val;
                end else begin
                    o_result = i_rs_val + i_rt_val;
                end
            end
            lc4_pkg::OP_LOGIC: begin
                if (insn[5]) begin
                    o_result = i_rs_val & imm5;
                end else begin
                    case (fn)
                        lc4_pkg::FN_AND: o_result = i_rs_val & i_rt_val;
                        lc4_pkg::FN_NOT: o_result = ~i_rs_val;
                        lc4_pkg::FN_OR:  o_result = i_rs_val | i_rt_val;
                        lc4_pkg::FN_XOR: o_result = i_rs_val ^ i_rt_val;
                        default:         o_result = '0;
                    endcase
                end
            end
            // effective address for the memory stage
            lc4_pkg::OP_LDR, lc4_pkg::OP_STR: o_result = i_rs_val + imm6;
            lc4_pkg::OP_CONST:                o_result = imm9;
            lc4_pkg::OP_HICONST:              o_result = {insn[7:0], i_rs_val[7:0]};
            default:                          o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/lc4_hazard.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_hazard (
    input  wire lc4_pkg::insn_ctrl_t i_d_ctrl,
    input  wire lc4_pkg::insn_ctrl_t i_x_ctrl,
    input  wire lc4_pkg::insn_ctrl_t i_m_ctrl,
    input  wire lc4_pkg::insn_ctrl_t i_w_ctrl,
    output logic                     o_stall,
    output lc4_pkg::bypass_e         o_rs_sel,
    output lc4_pkg::bypass_e         o_rt_sel,
    output lc4_pkg::bypass_e         o_store_sel,
    output lc4_pkg::nzp_src_e        o_nzp_sel
);

    logic rs_uses_load;
    logic rt_uses_load;
    logic br_uses_load;

    // youngest writer wins; a load in memory has no value yet
    function automatic lc4_pkg::bypass_e src_of(
        input lc4_pkg::reg_idx_t   idx,
        input logic                re,
        input lc4_pkg::insn_ctrl_t m,
        input lc4_pkg::insn_ctrl_t w
    );
        lc4_pkg::bypass_e sel;
        sel = lc4_pkg::BYP_REGFILE;
        if (re && m.rf_we && !m.is_load && m.rd == idx) begin
            sel = lc4_pkg::BYP_FROM_M;
        end else if (re && w.rf_we && w.rd == idx) begin
            sel = lc4_pkg::BYP_FROM_W;
        end
        return sel;
    endfunction

    assign rs_uses_load = i_d_ctrl.rs_re && i_d_ctrl.rs == i_x_ctrl.rd;
    // store data can still be patched in the memory stage
    assign rt_uses_load = i_d_ctrl.rt_re && !i_d_ctrl.is_store
                          && i_d_ctrl.rt == i_x_ctrl.rd;
    // a load sets nzp, so it is the newest condition source for the branch
    assign br_uses_load = i_d_ctrl.is_branch;

    assign o_stall = i_x_ctrl.is_load && (rs_uses_load || rt_uses_load || br_uses_load);

    assign o_rs_sel = src_of(i_x_ctrl.rs, i_x_ctrl.rs_re, i_m_ctrl, i_w_ctrl);
    assign o_rt_sel = src_of(i_x_ctrl.rt, i_x_ctrl.rt_re, i_m_ctrl, i_w_ctrl);

    assign o_store_sel = (i_m_ctrl.is_store && i_w_ctrl.rf_we && i_w_ctrl.rd == i_m_ctrl.rt)
                         ? lc4_pkg::BYP_FROM_W : lc4_pkg::BYP_REGFILE;

    always_comb begin
        if (i_m_ctrl.nzp_we) begin
            o_nzp_sel = lc4_pkg::NZP_FROM_M;
        end else if (i_w_ctrl.nzp_we) begin
            o_nzp_sel = lc4_pkg::NZP_FROM_W;
        end else begin
            o_nzp_sel = lc4_pkg::NZP_REG;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lc4_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_core #(
    parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
    input  wire                 gwe,
    input  wire                 i_rst_n,
    output lc4_pkg::word_t      o_imem_addr,
    input  wire lc4_pkg::word_t i_imem_data,
    output lc4_pkg::word_t      o_dmem_addr,
    output logic                o_dmem_we,
    output lc4_pkg::word_t      o_dmem_wdata,
    input  wire lc4_pkg::word_t i_dmem_rdata,
    output lc4_pkg::trace_t     o_trace
);

    lc4_pkg::word_t      pc_q;
    lc4_pkg::word_t      pc_d;
    lc4_pkg::word_t      fd_pc;
    lc4_pkg::word_t      fd_insn;
    lc4_pkg::stall_e     d_stall;
    lc4_pkg::stall_e     x_stall;
    lc4_pkg::stall_e     m_stall;
    lc4_pkg::stall_e     w_stall;
    lc4_pkg::dx_t        dx_q;
    lc4_pkg::xm_t        xm_q;
    lc4_pkg::mw_t        mw_q;
    lc4_pkg::nzp_t       nzp_q;
    lc4_pkg::insn_ctrl_t d_ctrl;
    lc4_pkg::word_t      rs_data;
    lc4_pkg::word_t      rt_data;
    logic                stall;
    lc4_pkg::bypass_e    rs_sel;
    lc4_pkg::bypass_e    rt_sel;
    lc4_pkg::bypass_e    store_sel;
    lc4_pkg::nzp_src_e   nzp_sel;
    lc4_pkg::word_t      x_rs_val;
    lc4_pkg::word_t      x_rt_val;
    lc4_pkg::nzp_t       x_nzp;
    lc4_pkg::word_t      alu_result;
    lc4_pkg::word_t      target;
    logic                taken;
    lc4_pkg::word_t      m_store_data;
    logic                m_is_mem;
    lc4_pkg::word_t      wb_value;
    lc4_pkg::nzp_t       m_nzp;
    lc4_pkg::nzp_t       w_nzp;

    function automatic lc4_pkg::nzp_t nzp_of(input lc4_pkg::word_t v);
        return v[15] ? 3'b100 : (v == '0) ? 3'b010 : 3'b001;
    endfunction

    lc4_decoder decoder_i (
        .i_insn (fd_insn),
        .o_ctrl (d_ctrl)
    );

    lc4_regfile regfile_i (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rs      (d_ctrl.rs),
        .i_rt      (d_ctrl.rt),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_rd      (mw_q.ctrl.rd),
        .i_wdata   (wb_value),
        .i_we      (mw_q.ctrl.rf_we)
    );

    lc4_hazard hazard_i (
        .i_d_ctrl    (d_ctrl),
        .i_x_ctrl    (dx_q.ctrl),
        .i_m_ctrl    (xm_q.ctrl),
        .i_w_ctrl    (mw_q.ctrl),
        .o_stall     (stall),
        .o_rs_sel    (rs_sel),
        .o_rt_sel    (rt_sel),
        .o_store_sel (store_sel),
        .o_nzp_sel   (nzp_sel)
    );

    lc4_alu alu_i (
        .i_ctrl   (dx_q.ctrl),
        .i_pc     (dx_q.pc),
        .i_rs_val (x_rs_val),
        .i_rt_val (x_rt_val),
        .i_nzp    (x_nzp),
        .o_result (alu_result),
        .o_taken  (taken),
        .o_target (target)
    );

    // fetch: a redirect beats the load-use hold
    always_comb begin
        if (taken) begin
            pc_d = target;
        end else if (stall) begin
            pc_d = pc_q;
        end else begin
            pc_d = pc_q + 16'd1;
        end
    end

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign o_imem_addr = pc_q;

    // F/D register holds on stall, squashed on redirect
    always_ff @(posedge gwe) begin
        if (!i_rst_n || taken) begin
            fd_pc   <= '0;
            fd_insn <= '0;
            d_stall <= lc4_pkg::STALL_FLUSH;
        end else if (!stall) begin
            fd_pc   <= pc_q;
            fd_insn <= i_imem_data;
            d_stall <= lc4_pkg::STALL_NONE;
        end
    end

    // D/X register takes a LOAD bubble while decode is held
    always_ff @(posedge gwe) begin
        if (!i_rst_n || taken) begin
            dx_q    <= '0;
            x_stall <= lc4_pkg::STALL_FLUSH;
        end else if (stall) begin
            dx_q    <= '0;
            x_stall <= lc4_pkg::STALL_LOAD;
        end else begin
            dx_q.ctrl   <= d_ctrl;
            dx_q.pc     <= fd_pc;
            dx_q.rs_val <= rs_data;
            dx_q.rt_val <= rt_data;
            x_stall     <= d_stall;
        end
    end

    // execute operand bypass
    always_comb begin
        case (rs_sel)
            lc4_pkg::BYP_FROM_M: x_rs_val = xm_q.result;
            lc4_pkg::BYP_FROM_W: x_rs_val = wb_value;
            default:             x_rs_val = dx_q.rs_val;
        endcase
        case (rt_sel)
            lc4_pkg::BYP_FROM_M: x_rt_val = xm_q.result;
            lc4_pkg::BYP_FROM_W: x_rt_val = wb_value;
            default:             x_rt_val = dx_q.rt_val;
        endcase
        case (nzp_sel)
            lc4_pkg::NZP_FROM_M: x_nzp = m_nzp;
            lc4_pkg::NZP_FROM_W: x_nzp = w_nzp;
            default:             x_nzp = nzp_q;
        endcase
    end

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            xm_q    <= '0;
            m_stall <= lc4_pkg::STALL_FLUSH;
            mw_q    <= '0;
            w_stall <= lc4_pkg::STALL_FLUSH;
        end else begin
            xm_q.ctrl       <= dx_q.ctrl;
            xm_q.pc         <= dx_q.pc;
            xm_q.result     <= alu_result;
            xm_q.store_data <= x_rt_val;
            m_stall         <= x_stall;
            mw_q.ctrl       <= xm_q.ctrl;
            mw_q.pc         <= xm_q.pc;
            mw_q.result     <= xm_q.result;
            mw_q.mem_data   <= xm_q.ctrl.is_store ? m_store_data : i_dmem_rdata;
            w_stall         <= m_stall;
        end
    end

    // memory stage, store data may come from a load now in writeback
    assign m_store_data = (store_sel == lc4_pkg::BYP_FROM_W) ? wb_value : xm_q.store_data;
    assign m_is_mem     = xm_q.ctrl.is_load || xm_q.ctrl.is_store;
    assign m_nzp        = nzp_of(xm_q.result);

    assign o_dmem_addr  = m_is_mem ? xm_q.result : '0;
    assign o_dmem_we    = xm_q.ctrl.is_store;
    assign o_dmem_wdata = m_store_data;

    // writeback
    assign wb_value = mw_q.ctrl.is_load ? mw_q.mem_data : mw_q.result;
    assign w_nzp    = nzp_of(wb_value);

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            nzp_q <= 3'b010;
        end else if (mw_q.ctrl.nzp_we) begin
            nzp_q <= w_nzp;
        end
    end

    always_comb begin
        o_trace           = '0;
        o_trace.stall     = w_stall;
        o_trace.pc        = mw_q.pc;
        o_trace.insn      = mw_q.ctrl.insn;
        o_trace.rf_we     = mw_q.ctrl.rf_we;
        o_trace.rf_wsel   = mw_q.ctrl.rd;
        o_trace.rf_data   = wb_value;
        o_trace.nzp_we    = mw_q.ctrl.nzp_we;
        o_trace.nzp_bits  = w_nzp;
        o_trace.dmem_we   = mw_q.ctrl.is_store;
        if (mw_q.ctrl.is_load || mw_q.ctrl.is_store) begin
            o_trace.dmem_addr = mw_q.result;
            o_trace.dmem_data = mw_q.mem_data;
        end
    end

endmodule

`default_nettype wire

// ==== bench/lc4_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_props (
    input wire                  gwe,
    input wire                  i_rst_n,
    input wire lc4_pkg::trace_t i_trace,
    input wire                  i_dmem_we,
    input wire lc4_pkg::word_t  i_dmem_addr
);

    // the first fetched instruction reaches memory in the fourth cycle
    logic [1:0] fill_cnt;

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            fill_cnt <= 2'd0;
        end else if (fill_cnt != 2'd3) begin
            fill_cnt <= fill_cnt + 2'd1;
        end
    end

    stall_code_legal: assert property (@(posedge gwe) disable iff (!i_rst_n)
        i_trace.stall != 2'd1)
        else $error("reserved stall code 1 on the trace");

    bubble_no_write: assert property (@(posedge gwe) disable iff (!i_rst_n)
        (i_trace.stall != lc4_pkg::STALL_NONE)
        |-> !(i_trace.rf_we || i_trace.nzp_we || i_trace.dmem_we))
        else $error("bubble on the trace carries a write");

    no_early_store: assert property (@(posedge gwe) disable iff (!i_rst_n)
        (fill_cnt != 2'd3) |-> !i_dmem_we)
        else $error("store reached memory while the pipeline was still filling");

    // a nonzero address belongs to the LDR or STR that retires one cycle later
    idle_addr_zero: assert property (@(posedge gwe) disable iff (!i_rst_n)
        (i_dmem_addr != 16'h0000)
        |=> (i_trace.stall == lc4_pkg::STALL_NONE
             && (i_trace.insn[15:12] == lc4_pkg::OP_LDR
                 || i_trace.insn[15:12] == lc4_pkg::OP_STR)))
        else $error("data memory address is not zero without an access");

endmodule

`default_nettype wire

// ==== bench/lc4_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_tb;

    localparam int          N_INSN         = 400;
    localparam int          RESET_CYCLES   = 2;
    localparam int          TIMEOUT_CYCLES = N_INSN * 3 + 100 + RESET_CYCLES;
    localparam logic [31:0] SEED           = 32'hee723f06;

    logic            gwe;
    logic            rst_n;
    lc4_pkg::word_t  imem_addr;
    lc4_pkg::word_t  imem_data;
    lc4_pkg::word_t  dmem_addr;
    logic            dmem_we;
    lc4_pkg::word_t  dmem_wdata;
    lc4_pkg::word_t  dmem_rdata;
    lc4_pkg::trace_t trace;

    logic [15:0] imem [1024];
    logic [15:0] dmem [256];
    logic [31:0] rng;

    // reference model state
    logic [15:0] m_regs [8];
    logic [15:0] m_mem [256];
    logic [2:0]  m_nzp;
    logic [15:0] m_pc;
    int          flush_due;
    int          load_due;
    logic        seen_first;
    logic        run_done;

    // predicted retirement of the instruction the model just stepped
    logic        exp_rf_we;
    logic [15:0] exp_data;
    logic        exp_nzp_we;
    logic [2:0]  exp_nzp;
    logic        exp_dmem_we;
    logic [15:0] exp_addr;
    logic [15:0] exp_mdata;
    logic        exp_taken;

    lc4_core #(
        .RESET_PC (16'h0000)
    ) lc4_core_i (
        .gwe          (gwe),
        .i_rst_n      (rst_n),
        .o_imem_addr  (imem_addr),
        .i_imem_data  (imem_data),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_we    (dmem_we),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_rdata (dmem_rdata),
        .o_trace      (trace)
    );

    bind lc4_core lc4_props props_i (
        .gwe         (gwe),
        .i_rst_n     (i_rst_n),
        .i_trace     (o_trace),
        .i_dmem_we   (o_dmem_we),
        .i_dmem_addr (o_dmem_addr)
    );

    // both memories answer in the same cycle
    assign imem_data  = imem[imem_addr[9:0]];
    assign dmem_rdata = dmem[dmem_addr[7:0]];

    always @(posedge gwe) begin
        if (dmem_we) begin
            dmem[dmem_addr[7:0]] <= dmem_wdata;
        end
    end

    initial begin
        gwe = 1'b0;
        forever #2 gwe = ~gwe;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] want);
        if (got !== want) begin
            $display("Fail %s: got %h, expected %h", name, got, want);
            $display("TEST RESULT: FAIL");
            $fatal(1, "run stopped at first mismatch");
        end
    endtask

    // one random instruction from the supported set
    // branch and jump offsets only go forward
    task automatic gen_insn(output logic [15:0] insn);
        logic [31:0] r;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [2:0]  rt;
        logic [4:0]  off;
        rng = xorshift32(rng);
        r   = rng;
        rd  = r[6:4];
        rs  = r[9:7];
        rt  = r[12:10];
        off = r[17:13] % 5'd7;
        case (r[3:0])
            4'd0:    insn = 16'h0000;
            4'd1:    insn = {lc4_pkg::OP_BR, r[20:18], 4'b0000, off};
            4'd2:    insn = {lc4_pkg::OP_ARITH, rd, rs, 3'b000, rt};
            4'd3:    insn = {lc4_pkg::OP_ARITH, rd, rs, 3'b010, rt};
            4'd4:    insn = {lc4_pkg::OP_ARITH, rd, rs, 1'b1, r[25:21]};
            4'd5:    insn = {lc4_pkg::OP_LOGIC, rd, rs, 3'b000, rt};
            4'd6:    insn = {lc4_pkg::OP_LOGIC, rd, rs, 3'b001, rt};
            4'd7:    insn = {lc4_pkg::OP_LOGIC, rd, rs, 3'b010, rt};
            4'd8:    insn = {lc4_pkg::OP_LOGIC, rd, rs, 3'b011, rt};
            4'd9:    insn = {lc4_pkg::OP_LOGIC, rd, rs, 1'b1, r[25:21]};
            4'd10,
            4'd11:   insn = {lc4_pkg::OP_LDR, rd, rs, r[26:21]};
            4'd12:   insn = {lc4_pkg::OP_STR, rd, rs, r[26:21]};
            4'd13:   insn = {lc4_pkg::OP_CONST, rd, r[31:23]};
            4'd14:   insn = {lc4_pkg::OP_HICONST, rd, 1'b1, r[31:24]};
            default: insn = {lc4_pkg::OP_JMP, 1'b1, 6'b000000, off};
        endcase
    endtask

    // true when insn must wait for a load into register r
    function automatic logic reads_load_result(input logic [15:0] insn, input logic [2:0] r);
        logic [3:0] op;
        logic       rs_used;
        logic       rt_used;
        op      = insn[15:12];
        rs_used = op == lc4_pkg::OP_ARITH || op == lc4_pkg::OP_LOGIC
                  || op == lc4_pkg::OP_LDR || op == lc4_pkg::OP_STR;
        // NOT has no second source
        // STR data is patched in the memory stage
        rt_used = (op == lc4_pkg::OP_ARITH || op == lc4_pkg::OP_LOGIC) && !insn[5]
                  && !(op == lc4_pkg::OP_LOGIC && insn[4:3] == 2'b01);
        if (op == lc4_pkg::OP_BR) begin
            return |insn[11:9];
        end
        if (op == lc4_pkg::OP_HICONST) begin
            return insn[11:9] == r;
        end
        return (rs_used && insn[8:6] == r) || (rt_used && insn[2:0] == r);
    endfunction

    // architectural step of one instruction
    task automatic model_exec(input logic [15:0] insn);
        logic [2:0]  rd;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic [15:0] sext5;
        logic [15:0] sext6;
        logic [15:0] sext9;
        logic [15:0] sext11;
        rd          = insn[11:9];
        a           = m_regs[insn[8:6]];
        b           = m_regs[insn[2:0]];
        sext5       = {{11{insn[4]}}, insn[4:0]};
        sext6       = {{10{insn[5]}}, insn[5:0]};
        sext9       = {{7{insn[8]}}, insn[8:0]};
        sext11      = {{5{insn[10]}}, insn[10:0]};
        res         = 16'h0000;
        exp_rf_we   = 1'b0;
        exp_dmem_we = 1'b0;
        exp_addr    = 16'h0000;
        exp_mdata   = 16'h0000;
        exp_taken   = 1'b0;
        case (insn[15:12])
            lc4_pkg::OP_BR: begin
                exp_taken = |(insn[11:9] & m_nzp);
            end
            lc4_pkg::OP_ARITH: begin
                if (insn[5]) begin
                    res = a + sext5;
                end else if (insn[4:3] == 2'b10) begin
                    res = a - b;
                end else begin
                    res = a + b;
                end
                exp_rf_we = 1'b1;
            end
            lc4_pkg::OP_LOGIC: begin
                if (insn[5]) begin
                    res = a & sext5;
                end else begin
                    case (insn[4:3])
                        2'b00:   res = a & b;
                        2'b01:   res = ~a;
                        2'b10:   res = a | b;
                        default: res = a ^ b;
                    endcase
                end
                exp_rf_we = 1'b1;
            end
            lc4_pkg::OP_LDR: begin
                exp_addr  = a + sext6;
                res       = m_mem[exp_addr[7:0]];
                exp_mdata = res;
                exp_rf_we = 1'b1;
            end
            lc4_pkg::OP_STR: begin
                exp_addr    = a + sext6;
                exp_mdata   = m_regs[rd];
                exp_dmem_we = 1'b1;
                m_mem[exp_addr[7:0]] = exp_mdata;
            end
            lc4_pkg::OP_CONST: begin
                res       = sext9;
                exp_rf_we = 1'b1;
            end
            lc4_pkg::OP_HICONST: begin
                res       = {insn[7:0], m_regs[rd][7:0]};
                exp_rf_we = 1'b1;
            end
            lc4_pkg::OP_JMP: begin
                exp_taken = 1'b1;
            end
            default: begin
            end
        endcase
        // every register writer in this set also sets the condition code
        exp_nzp_we = exp_rf_we;
        exp_data   = res;
        if (res[15]) begin
            exp_nzp = 3'b100;
        end else if (res == 16'h0000) begin
            exp_nzp = 3'b010;
        end else begin
            exp_nzp = 3'b001;
        end
        if (exp_rf_we) begin
            m_regs[rd] = res;
            m_nzp      = exp_nzp;
        end
        if (exp_taken) begin
            m_pc = m_pc + 16'd1 + (insn[15:12] == lc4_pkg::OP_JMP ? sext11 : sext9);
        end else begin
            m_pc = m_pc + 16'd1;
        end
    endtask

    task automatic check_cycle();
        logic [15:0] insn;
        logic [15:0] pc;
        if (trace.stall == lc4_pkg::STALL_FLUSH) begin
            // the pipe drains reset bubbles before the first instruction
            if (seen_first && flush_due == 0) begin
                fail_now("flush bubble retired without a taken branch or jump before it");
            end else if (seen_first) begin
                flush_due = flush_due - 1;
            end
        end else if (trace.stall == lc4_pkg::STALL_LOAD) begin
            if (load_due == 0) begin
                fail_now("load bubble retired without a load-use hazard before it");
            end else begin
                load_due = load_due - 1;
            end
        end else if (trace.stall == lc4_pkg::STALL_NONE) begin
            if (flush_due != 0 || load_due != 0) begin
                fail_now("instruction retired before the expected bubbles");
            end else begin
                pc   = m_pc;
                insn = imem[pc[9:0]];
                check_val("trace.pc", trace.pc, pc);
                check_val("trace.insn", trace.insn, insn);
                model_exec(insn);
                check_val("trace.rf_we", 16'(trace.rf_we), 16'(exp_rf_we));
                if (exp_rf_we) begin
                    check_val("trace.rf_wsel", 16'(trace.rf_wsel), 16'(insn[11:9]));
                    check_val("trace.rf_data", trace.rf_data, exp_data);
                end
                check_val("trace.nzp_we", 16'(trace.nzp_we), 16'(exp_nzp_we));
                if (exp_nzp_we) begin
                    check_val("trace.nzp_bits", 16'(trace.nzp_bits), 16'(exp_nzp));
                end
                check_val("trace.dmem_we", 16'(trace.dmem_we), 16'(exp_dmem_we));
                check_val("trace.dmem_addr", trace.dmem_addr, exp_addr);
                check_val("trace.dmem_data", trace.dmem_data, exp_mdata);
                if (exp_dmem_we) begin
                    check_val("dmem word", dmem[exp_addr[7:0]], m_mem[exp_addr[7:0]]);
                end
                seen_first = 1'b1;
                if (exp_taken) begin
                    flush_due = 2;
                end
                if (insn[15:12] == lc4_pkg::OP_LDR
                    && reads_load_result(imem[m_pc[9:0]], insn[11:9])) begin
                    load_due = 1;
                end
                if (pc >= 16'(N_INSN)) begin
                    run_done = 1'b1;
                end
            end
        end else begin
            fail_now("trace stall code is not a legal value");
        end
    endtask

    always @(posedge gwe) begin
        if (rst_n && !run_done) begin
            check_cycle();
        end
    end

    initial begin
        int i;
        rst_n      = 1'b0;
        rng        = SEED;
        m_nzp      = 3'b010;
        m_pc       = 16'h0000;
        flush_due  = 0;
        load_due   = 0;
        seen_first = 1'b0;
        run_done   = 1'b0;
        for (i = 0; i < 1024; i++) begin
            imem[i] = 16'h0000;
        end
        for (i = 0; i < N_INSN; i++) begin
            gen_insn(imem[i]);
        end
        for (i = 0; i < 256; i++) begin
            rng      = xorshift32(rng);
            dmem[i]  = rng[15:0];
            m_mem[i] = rng[15:0];
        end
        for (i = 0; i < 8; i++) begin
            m_regs[i] = 16'h0000;
        end
        repeat (RESET_CYCLES) @(posedge gwe);
        rst_n <= 1'b1;
        wait (run_done);
        for (i = 0; i < 256; i++) begin
            check_val("dmem word", dmem[i], m_mem[i]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // worst case is a bubble pair or a load bubble per instruction
    initial begin
        #(TIMEOUT_CYCLES * 4);
        fail_now("watchdog expired before the program reached its end");
    end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/lc4_pkg.sv
rtl/lc4_decoder.sv
rtl/lc4_regfile.sv
rtl/lc4_alu.sv
rtl/lc4_hazard.sv
rtl/lc4_core.sv
bench/lc4_props.sv
bench/lc4_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the LC4 pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module lc4_tb -Mdir obj_dir -o lc4_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/lc4_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    exit 0
fi
exit 1
